//--- verification/mem_patterns.txt
// op addr wdata exp_data exp_hit exp_err
// op 1 = rd, 2 = wr, 3 = rd and wr together
1 0010 0000 0000 0 0
1 0010 0000 0000 1 0
2 0012 A5A5 A5A5 1 0
1 0012 0000 A5A5 1 0
1 0014 0000 0000 1 0
2 0828 1111 1111 0 0
2 1028 2222 2222 0 0
1 0828 0000 1111 1 0
1 1028 0000 2222 1 0
1 1828 0000 0000 0 0
1 1028 0000 2222 1 0
1 0828 0000 1111 0 0
1 1028 0000 2222 0 0
1 1828 0000 0000 0 0
1 102A 0000 0000 1 0
1 0011 0000 0000 0 1
3 0012 FFFF 0000 0 1
1 0012 0000 A5A5 1 0
2 102B BEEF 0000 0 1
1 102A 0000 0000 1 0
1 0010 0000 0000 1 0

//--- project.f
hdl/cache_pkg.sv
hdl/mem_pkg.sv
hdl/cache_way.sv
hdl/banked_mem.sv
hdl/cache_control.sv
hdl/mem_system.sv
verification/tb_clock.sv
verification/mem_system_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the mem_system testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module mem_system_tb -Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/Vmem_system_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
   echo "Simulation failed"
   exit 1
fi
if ! grep -q "NO ERRORS" "$LOG"; then
   echo "No result line found in $LOG"
   exit 1
fi
echo "Simulation passed"
exit 0

//--- verification/mem_system_tb.sv
// Testbench for the cached memory system
// Replays requests from the patterns file and checks read data, hit,
// err, done latency, stall and the held data_out of each request

`default_nettype none
module mem_system_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int DATA_W             = 16;
   localparam int MEM_LATENCY        = 4;
   localparam int RESET_CYCLES       = 5;
   localparam int MAX_PATTERNS       = 64;
   localparam int FIELDS             = 6;   // Columns per request
   localparam int CYCLES_PER_PATTERN = 200;

   logic clk;
   logic rst;
   logic [mem_pkg::MEM_ADDR_W-1:0] addr;
   logic [DATA_W-1:0] data_in;
   logic rd;
   logic wr;
   logic [DATA_W-1:0] data_out;
   logic done;
   logic stall;
   logic cache_hit;
   logic err;

   logic [15:0] patterns [MAX_PATTERNS*FIELDS];
   logic [DATA_W-1:0] held_data;
   int num_patterns;
   int errors = 0;
   int tests_passed = 0;
   int tests_failed = 0;
   int cycle_count = 0;
   int cycle_limit = 0;

   tb_clock clock_gen (.clk(clk));

   mem_system #(.DATA_W(DATA_W), .MEM_LATENCY(MEM_LATENCY)) dut_i (
      .clk(clk), .rst(rst), .addr(addr), .data_in(data_in), .rd(rd), .wr(wr),
      .data_out(data_out), .done(done), .stall(stall),
      .cache_hit(cache_hit), .err(err)
   );

   task automatic finish_run(input bit timed_out);
      $display("Summary: %0d tests run, %0d passed, %0d failed, %0d failed checks",
               tests_passed + tests_failed, tests_passed, tests_failed, errors);
      if (errors == 0 && !timed_out) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   endtask

   task automatic check_value(input string test, input string what,
                              input logic [15:0] expected, input logic [15:0] actual);
      assert (actual === expected)
      else begin
         $display("Fail %s %s expected 0x%04h actual 0x%04h", test, what, expected, actual);
         errors++;
      end
   endtask

   task automatic check_true(input bit cond, input string msg);
      assert (cond)
      else begin
         $display("%s", msg);
         errors++;
      end
   endtask

   task automatic run_test(input int n);
      logic [3:0] op;
      logic [15:0] req_addr;
      logic [15:0] wdata;
      logic [15:0] exp_data;
      logic exp_hit;
      logic exp_err;
      string op_name;
      string name;
      int cycles;
      int latency;
      int errors_before;
      bit seen_done;

      op       = patterns[n*FIELDS][3:0];
      req_addr = patterns[n*FIELDS+1];
      wdata    = patterns[n*FIELDS+2];
      exp_data = patterns[n*FIELDS+3];
      exp_hit  = patterns[n*FIELDS+4][0];
      exp_err  = patterns[n*FIELDS+5][0];
      case (op)
         4'h1: op_name = "rd";
         4'h2: op_name = "wr";
         4'h3: op_name = "rd+wr";
         default: op_name = "bad op";
      endcase
      name = $sformatf("t%0d %s 0x%04h", n + 1, op_name, req_addr);
      errors_before = errors;

      @(posedge clk);
      #1;
      addr    = req_addr;
      data_in = wdata;
      rd      = op[0];
      wr      = op[1];

      cycles    = 0;
      seen_done = 1'b0;
      while (!seen_done) begin
         @(negedge clk);   // Outputs settled mid-cycle
         cycles++;
         if (cycles == 1)
            check_value(name, "held data_out", held_data, data_out);
         if (done) begin
            seen_done = 1'b1;
         end else begin
            // Idle in the request cycle, busy until done
            check_true(stall == (cycles > 1),
                       $sformatf("%s: stall was %0b in cycle %0d", name, stall, cycles));
            check_true(!cache_hit && !err,
                       $sformatf("%s: cache_hit or err pulsed without done", name));
         end
      end

      latency = cycles - 1;
      check_true(!stall, $sformatf("%s: stall stayed high on the done cycle", name));
      check_value(name, "data_out", exp_data, data_out);
      check_value(name, "cache_hit", 16'(exp_hit), 16'(cache_hit));
      check_value(name, "err", 16'(exp_err), 16'(err));
      if (exp_err)
         check_value(name, "done latency", 16'd1, 16'(latency));
      else if (exp_hit)
         check_value(name, "done latency", 16'd2, 16'(latency));
      else
         check_true(latency > 2,
                    $sformatf("%s: miss finished after only %0d cycles", name, latency));
      held_data = data_out;

      @(posedge clk);
      #1;
      rd = 1'b0;
      wr = 1'b0;

      if (errors == errors_before) begin
         tests_passed++;
         $display("%s: ok, done after %0d cycles", name, latency);
      end else begin
         tests_failed++;
         $display("%s: failed", name);
      end
   endtask

   // Run limit grows with the number of requests
   always @(posedge clk) begin
      cycle_count++;
      if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
         $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
         finish_run(1'b1);
      end
   end

   initial begin
      rst       = 1'b1;
      addr      = '0;
      data_in   = '0;
      rd        = 1'b0;
      wr        = 1'b0;
      held_data = '0;
      for (int i = 0; i < MAX_PATTERNS*FIELDS; i++)
         patterns[i] = '0;
      $readmemh("verification/mem_patterns.txt", patterns);
      num_patterns = 0;
      while (num_patterns < MAX_PATTERNS && patterns[num_patterns*FIELDS] != '0)
         num_patterns++;   // Op 0 ends the list
      cycle_limit = RESET_CYCLES + CYCLES_PER_PATTERN * num_patterns;
      check_true(num_patterns > 0, "No requests read from the patterns file");

      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      rst = 1'b0;

      for (int n = 0; n < num_patterns; n++)
         run_test(n);
      finish_run(1'b0);
   end

endmodule
`default_nettype wire

//--- verification/tb_clock.sv
// Testbench clock source
// Free-running clock, 10 ns period, starts low

`default_nettype none
module tb_clock #(
   parameter int HALF_PERIOD = 5
) (
   output logic clk
);
   timeunit 1ns;
   timeprecision 100ps;

   initial clk = 1'b0;

   always #(HALF_PERIOD) clk = ~clk;

endmodule
`default_nettype wire

//--- hdl/mem_system.sv
// Cached memory system top level
// Two cache ways, banked main memory and the controller, plus the
// hit merge, way select, victim flop and the data_out register

`default_nettype none
module mem_system #(
   parameter int DATA_W      = 16,
   parameter int MEM_LATENCY = 4
) (
   input  logic                          clk,
   input  logic                          rst,
   input  logic [mem_pkg::MEM_ADDR_W-1:0] addr,
   input  logic [DATA_W-1:0]              data_in,
   input  logic                          rd,
   input  logic                          wr,
   output logic [DATA_W-1:0]              data_out,
   output logic                          done,
   output logic                          stall,
   output logic                          cache_hit,
   output logic                          err
);

   logic [1:0] enable_way;
   logic [cache_pkg::TAG_W-1:0] tag_in, tag_out_0, tag_out_1, tag_out_sel;
   logic [cache_pkg::INDEX_W-1:0] index;
   logic [cache_pkg::OFFSET_W-1:0] offset;
   logic [DATA_W-1:0] way_data_in, data_out_0, data_out_1, data_out_sel;
   logic [DATA_W-1:0] result_data, data_q;
   logic comp, write, valid_in;
   logic hit_0, dirty_0, valid_0;
   logic hit_1, dirty_1, valid_1;
   logic merged_hit, way_sel;
   logic victim_d, victim_q;
   logic [mem_pkg::MEM_ADDR_W-1:0] mem_addr;
   logic [DATA_W-1:0] mem_data_in, mem_data_out;
   mem_pkg::bank_op_t mem_op;
   logic mem_stall;
   logic [mem_pkg::BANKS-1:0] mem_busy;

   cache_way #(.DATA_W(DATA_W)) way_0 (
      .clk(clk), .rst(rst), .enable(enable_way[0]),
      .tag_in(tag_in), .index(index), .offset(offset), .data_in(way_data_in),
      .comp(comp), .write(write), .valid_in(valid_in),
      .tag_out(tag_out_0), .data_out(data_out_0),
      .hit(hit_0), .dirty(dirty_0), .valid(valid_0)
   );

   cache_way #(.DATA_W(DATA_W)) way_1 (
      .clk(clk), .rst(rst), .enable(enable_way[1]),
      .tag_in(tag_in), .index(index), .offset(offset), .data_in(way_data_in),
      .comp(comp), .write(write), .valid_in(valid_in),
      .tag_out(tag_out_1), .data_out(data_out_1),
      .hit(hit_1), .dirty(dirty_1), .valid(valid_1)
   );

   banked_mem #(.DATA_W(DATA_W), .MEM_LATENCY(MEM_LATENCY)) mem (
      .clk(clk), .rst(rst), .addr(mem_addr), .data_in(mem_data_in), .op(mem_op),
      .data_out(mem_data_out), .stall(mem_stall), .busy(mem_busy)
   );

   cache_control #(.DATA_W(DATA_W), .MEM_LATENCY(MEM_LATENCY)) control (
      .clk(clk), .rst(rst), .addr(addr), .data_in(data_in), .rd(rd), .wr(wr),
      .hit_0(hit_0), .dirty_0(dirty_0), .valid_0(valid_0),
      .hit_1(hit_1), .dirty_1(dirty_1), .valid_1(valid_1),
      .tag_out_sel(tag_out_sel), .data_out_sel(data_out_sel),
      .merged_hit(merged_hit), .victim_q(victim_q),
      .mem_data_out(mem_data_out), .mem_stall(mem_stall), .mem_busy(mem_busy),
      .enable_way(enable_way), .tag_in(tag_in), .index(index), .offset(offset),
      .way_data_in(way_data_in), .comp(comp), .write(write), .valid_in(valid_in),
      .mem_addr(mem_addr), .mem_data_in(mem_data_in), .mem_op(mem_op),
      .result_data(result_data), .done(done), .stall(stall),
      .cache_hit(cache_hit), .err(err), .victim_d(victim_d), .way_sel(way_sel)
   );

   assign merged_hit   = (valid_0 & hit_0) | (valid_1 & hit_1);
   assign tag_out_sel  = way_sel ? tag_out_1 : tag_out_0;
   assign data_out_sel = way_sel ? data_out_1 : data_out_0;
   assign data_out     = done ? result_data : data_q;   // Live on done, held after

   always_ff @(posedge clk) begin
      if (rst) begin
         victim_q <= 1'b0;
         data_q   <= '0;
      end else begin
         victim_q <= victim_d;
         if (done)
            data_q <= result_data;
      end
   end

endmodule
`default_nettype wire

//--- hdl/cache_control.sv
// Cache controller FSM
// Decodes requester strobes, checks both ways, and on a miss writes
// back a dirty victim then fills the line from banked memory.
// Fills are pipelined across banks and tracked until the last returns.

`default_nettype none
module cache_control #(
   parameter int DATA_W      = 16,
   parameter int MEM_LATENCY = 4
) (
   input  logic                           clk,
   input  logic                           rst,
   input  logic [mem_pkg::MEM_ADDR_W-1:0]  addr,
   input  logic [DATA_W-1:0]               data_in,
   input  logic                           rd,
   input  logic                           wr,
   input  logic                           hit_0,
   input  logic                           dirty_0,
   input  logic                           valid_0,
   input  logic                           hit_1,
   input  logic                           dirty_1,
   input  logic                           valid_1,
   input  logic [cache_pkg::TAG_W-1:0]     tag_out_sel,
   input  logic [DATA_W-1:0]               data_out_sel,
   input  logic                           merged_hit,
   input  logic                           victim_q,
   input  logic [DATA_W-1:0]               mem_data_out,
   input  logic                           mem_stall,
   input  logic [mem_pkg::BANKS-1:0]       mem_busy,
   output logic [1:0]                     enable_way,
   output logic [cache_pkg::TAG_W-1:0]     tag_in,
   output logic [cache_pkg::INDEX_W-1:0]   index,
   output logic [cache_pkg::OFFSET_W-1:0]  offset,
   output logic [DATA_W-1:0]               way_data_in,
   output logic                           comp,
   output logic                           write,
   output logic                           valid_in,
   output logic [mem_pkg::MEM_ADDR_W-1:0]  mem_addr,
   output logic [DATA_W-1:0]               mem_data_in,
   output mem_pkg::bank_op_t               mem_op,
   output logic [DATA_W-1:0]               result_data,
   output logic                           done,
   output logic                           stall,
   output logic                           cache_hit,
   output logic                           err,
   output logic                           victim_d,
   output logic                           way_sel
);

   cache_pkg::ctrl_state_t state;
   logic [cache_pkg::TAG_W-1:0] tag_q;
   logic [cache_pkg::INDEX_W-1:0] index_q;
   logic [cache_pkg::OFFSET_W-1:0] offset_q;
   logic [DATA_W-1:0] data_q;
   logic wr_q;
   logic hit_q;
   logic vway;
   logic [cache_pkg::WORD_SEL_W-1:0] cnt;    // Next word to issue
   logic [cache_pkg::WORD_SEL_W-1:0] rcnt;   // Next word to return
   logic [2:0] in_flight;
   logic [MEM_LATENCY-1:0] rd_pipe;
   logic victim;
   logic victim_dirty;
   logic bad_req;
   logic accept;
   logic issue_rd;
   logic ret_valid;

   assign bad_req      = (rd & wr) | addr[0];
   assign victim       = !valid_0 ? 1'b0 : (!valid_1 ? 1'b1 : victim_q);
   assign victim_dirty = victim ? (valid_1 & dirty_1) : (valid_0 & dirty_0);
   assign victim_d     = victim_q ^ (state == cache_pkg::COMPARE && !merged_hit
                                     && valid_0 && valid_1);

   assign accept    = (state == cache_pkg::WB_REQ || state == cache_pkg::FILL_REQ)
                      && !mem_busy[cnt] && !mem_stall;
   assign issue_rd  = accept && state == cache_pkg::FILL_REQ;
   assign ret_valid = rd_pipe[MEM_LATENCY-1];

   assign done      = (state == cache_pkg::DONE) || (state == cache_pkg::ERR);
   assign err       = (state == cache_pkg::ERR);
   assign cache_hit = (state == cache_pkg::DONE) && hit_q;
   assign stall     = !(state inside {cache_pkg::IDLE, cache_pkg::DONE, cache_pkg::ERR});

   always_comb begin
      enable_way  = '0;
      tag_in      = tag_q;
      index       = index_q;
      offset      = offset_q;
      way_data_in = data_q;
      comp        = 1'b0;
      write       = 1'b0;
      valid_in    = 1'b0;
      way_sel     = vway;
      mem_op      = mem_pkg::OP_NONE;
      mem_addr    = {tag_q, index_q, cnt, 1'b0};
      mem_data_in = data_out_sel;
      unique case (state)
         cache_pkg::COMPARE: begin
            enable_way = 2'b11;
            comp       = 1'b1;
            write      = wr_q;
            way_sel    = valid_1 & hit_1 & ~(valid_0 & hit_0);   // Way 0 wins a double match
         end
         cache_pkg::WB_REQ: begin
            enable_way = 2'b01 << vway;
            offset     = {cnt, 1'b0};
            mem_op     = mem_pkg::OP_WR;
            mem_addr   = {tag_out_sel, index_q, cnt, 1'b0};   // Victim's own tag
         end
         cache_pkg::FILL_REQ: mem_op = mem_pkg::OP_RD;
         cache_pkg::INSTALL: begin
            enable_way = 2'b01 << vway;
            comp       = 1'b1;
            write      = wr_q;
         end
         default: ;
      endcase
      // Returning fill word goes straight into the victim way
      if (ret_valid) begin
         enable_way  = 2'b01 << vway;
         offset      = {rcnt, 1'b0};
         way_data_in = mem_data_out;
         write       = 1'b1;
         valid_in    = 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= cache_pkg::IDLE;
         cnt       <= '0;
         rcnt      <= '0;
         in_flight <= '0;
         rd_pipe   <= '0;
         hit_q     <= 1'b0;
         vway      <= 1'b0;
      end else begin
         rd_pipe   <= (rd_pipe << 1) | MEM_LATENCY'(issue_rd);
         in_flight <= in_flight + 3'(issue_rd) - 3'(ret_valid);
         if (ret_valid)
            rcnt <= rcnt + 1'b1;
         if (accept)
            cnt <= cnt + 1'b1;   // Wraps to zero after each line
         unique case (state)
            cache_pkg::IDLE:
               if (rd | wr)
                  state <= bad_req ? cache_pkg::ERR : cache_pkg::COMPARE;
            cache_pkg::COMPARE: begin
               hit_q <= merged_hit;
               if (merged_hit) begin
                  state <= cache_pkg::DONE;
               end else begin
                  vway  <= victim;
                  state <= victim_dirty ? cache_pkg::WB_REQ : cache_pkg::FILL_REQ;
               end
            end
            cache_pkg::WB_REQ:
               if (accept && cnt == cache_pkg::WORD_SEL_W'(cache_pkg::WORDS_PER_LINE - 1))
                  state <= cache_pkg::WB_WAIT;
            cache_pkg::WB_WAIT:
               if (mem_busy == '0)
                  state <= cache_pkg::FILL_REQ;
            cache_pkg::FILL_REQ:
               if (accept && cnt == cache_pkg::WORD_SEL_W'(cache_pkg::WORDS_PER_LINE - 1))
                  state <= cache_pkg::FILL_WAIT;
            cache_pkg::FILL_WAIT:
               if (ret_valid && in_flight == 3'd1)   // Last word back
                  state <= cache_pkg::INSTALL;
            cache_pkg::INSTALL: state <= cache_pkg::DONE;
            default: state <= cache_pkg::IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == cache_pkg::IDLE) begin
         tag_q       <= addr[mem_pkg::MEM_ADDR_W-1 -: cache_pkg::TAG_W];
         index_q     <= addr[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];
         offset_q    <= addr[cache_pkg::OFFSET_W-1:0];
         data_q      <= data_in;
         wr_q        <= wr;
         result_data <= '0;   // Errors return zero
      end
      if ((state == cache_pkg::COMPARE && merged_hit) || state == cache_pkg::INSTALL)
         result_data <= wr_q ? data_q : data_out_sel;
   end

endmodule
`default_nettype wire

//--- hdl/banked_mem.sv
// Four-bank interleaved main memory
// Bank is picked by word address bits 2:1. An accepted access keeps
// its bank busy for MEM_LATENCY cycles; read data shows on data_out
// exactly MEM_LATENCY cycles after acceptance.

`default_nettype none
module banked_mem #(
   parameter int DATA_W      = 16,
   parameter int MEM_LATENCY = 4
) (
   input  logic                           clk,
   input  logic                           rst,
   input  logic [mem_pkg::MEM_ADDR_W-1:0]  addr,
   input  logic [DATA_W-1:0]               data_in,
   input  mem_pkg::bank_op_t               op,
   output logic [DATA_W-1:0]               data_out,
   output logic                           stall,
   output logic [mem_pkg::BANKS-1:0]       busy
);

   localparam int CNT_W = $clog2(MEM_LATENCY + 1);
   localparam int ROW_W = mem_pkg::MEM_ADDR_W - mem_pkg::BANK_SEL_W - 1;
   localparam int ROWS  = 2 ** ROW_W;

   logic [DATA_W-1:0] mem [mem_pkg::BANKS][ROWS] = '{default: '0};
   logic [DATA_W-1:0] rd_data [mem_pkg::BANKS];
   logic [CNT_W-1:0] count [mem_pkg::BANKS];
   logic [mem_pkg::BANKS-1:0] rd_pend;
   logic [mem_pkg::BANK_SEL_W-1:0] bank;
   logic [ROW_W-1:0] row;
   logic accept;

   assign bank   = addr[mem_pkg::BANK_SEL_W:1];
   assign row    = addr[mem_pkg::MEM_ADDR_W-1:mem_pkg::BANK_SEL_W+1];
   assign stall  = (op != mem_pkg::OP_NONE) && busy[bank];
   assign accept = (op != mem_pkg::OP_NONE) && !busy[bank];

   always_comb begin
      for (int b = 0; b < mem_pkg::BANKS; b++)
         busy[b] = (count[b] != '0);
   end

   // Latency counters per bank
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int b = 0; b < mem_pkg::BANKS; b++)
            count[b] <= '0;
         rd_pend <= '0;
      end else begin
         for (int b = 0; b < mem_pkg::BANKS; b++) begin
            if (accept && bank == mem_pkg::BANK_SEL_W'(b)) begin
               count[b]   <= CNT_W'(MEM_LATENCY);
               rd_pend[b] <= (op == mem_pkg::OP_RD);
            end else if (count[b] != '0) begin
               count[b] <= count[b] - 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept && op == mem_pkg::OP_WR)
         mem[bank][row] <= data_in;
      if (accept && op == mem_pkg::OP_RD)
         rd_data[bank] <= mem[bank][row];   // Held until the last busy cycle
   end

   // At most one bank is on its final cycle at a time
   always_comb begin
      data_out = '0;
      for (int b = 0; b < mem_pkg::BANKS; b++) begin
         if (rd_pend[b] && count[b] == CNT_W'(1))
            data_out = rd_data[b];
      end
   end

endmodule
`default_nettype wire

//--- hdl/cache_way.sv
// One way of the set-associative cache
// Tag, valid, dirty and data arrays with combinational read.
// Compare mode checks the tag and may write a word and set dirty;
// access mode writes word, tag and valid directly and clears dirty.

`default_nettype none
module cache_way #(
   parameter int DATA_W = 16
) (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          enable,
   input  logic [cache_pkg::TAG_W-1:0]    tag_in,
   input  logic [cache_pkg::INDEX_W-1:0]  index,
   input  logic [cache_pkg::OFFSET_W-1:0] offset,
   input  logic [DATA_W-1:0]              data_in,
   input  logic                          comp,
   input  logic                          write,
   input  logic                          valid_in,
   output logic [cache_pkg::TAG_W-1:0]    tag_out,
   output logic [DATA_W-1:0]              data_out,
   output logic                          hit,
   output logic                          dirty,
   output logic                          valid
);

   logic [cache_pkg::TAG_W-1:0] tag_arr [cache_pkg::LINES];
   logic [DATA_W-1:0] data_arr [cache_pkg::LINES][cache_pkg::WORDS_PER_LINE];
   logic [cache_pkg::LINES-1:0] valid_arr;
   logic [cache_pkg::LINES-1:0] dirty_arr;
   logic [cache_pkg::WORD_SEL_W-1:0] word;
   logic tag_match;
   logic wr_word;

   assign word      = offset[cache_pkg::OFFSET_W-1:1];   // Bit 0 is the byte select
   assign tag_match = (tag_arr[index] == tag_in);

   assign tag_out  = tag_arr[index];
   assign data_out = data_arr[index][word];
   assign valid    = valid_arr[index];
   assign dirty    = dirty_arr[index];
   assign hit      = enable & comp & tag_match;

   // Compare writes only land on a resident line
   assign wr_word = enable & write & (~comp | (tag_match & valid_arr[index]));

   always_ff @(posedge clk) begin
      if (rst) begin
         valid_arr <= '0;
         dirty_arr <= '0;
      end else if (wr_word) begin
         if (comp) begin
            dirty_arr[index] <= 1'b1;
         end else begin
            valid_arr[index] <= valid_in;
            dirty_arr[index] <= 1'b0;   // Fresh from memory
         end
      end
   end

   always_ff @(posedge clk) begin
      if (wr_word) begin
         data_arr[index][word] <= data_in;
         if (!comp)
            tag_arr[index] <= tag_in;
      end
   end

endmodule
`default_nettype wire

//--- hdl/mem_pkg.sv
// Main memory geometry and bank operation encoding
// Four word-interleaved banks behind a 16-bit byte address

`default_nettype none
package mem_pkg;

   localparam int BANKS      = 4;
   localparam int BANK_SEL_W = $clog2(BANKS);
   localparam int MEM_ADDR_W = 16;

   typedef enum logic [1:0] {
      OP_NONE,
      OP_RD,
      OP_WR
   } bank_op_t;

endpackage
`default_nettype wire

//--- hdl/cache_pkg.sv
// Cache geometry and controller state encoding
// Two-way set-associative cache, four 16-bit words per line

`default_nettype none
package cache_pkg;

   // Byte address split is tag | index | offset
   localparam int TAG_W    = 5;
   localparam int INDEX_W  = 8;
   localparam int OFFSET_W = 3;

   localparam int WORDS_PER_LINE = 4;
   localparam int WORD_SEL_W     = $clog2(WORDS_PER_LINE);
   localparam int LINES          = 2 ** INDEX_W;

   typedef enum logic [3:0] {
      IDLE,
      COMPARE,    // Tag check in both ways
      WB_REQ,     // Dirty victim out to memory
      WB_WAIT,
      FILL_REQ,
      FILL_WAIT,
      INSTALL,    // Requested word read or merged
      DONE,
      ERR
   } ctrl_state_t;

endpackage
`default_nettype wire
